/* sim.f */
src/wb_pkg.sv
src/csr_if.sv
src/wb_stage.sv
src/csr_file.sv
src/reg_file.sv
src/wb_subsystem_top.sv
sim/tb_wb_subsystem.sv

/* Bender.yml */
package:
  name: wb_subsystem

sources:
  - src/wb_pkg.sv
  - src/csr_if.sv
  - src/wb_stage.sv
  - src/csr_file.sv
  - src/reg_file.sv
  - src/wb_subsystem_top.sv
  - target: simulation
    files:
      - sim/tb_wb_subsystem.sv

/* sim/tb_wb_subsystem.sv */
module tb_wb_subsystem;
    timeunit 1ns;
    timeprecision 1ps;
    import wb_pkg::*;

    localparam logic [xlen-1:0] eentry_reset = 32'h1c00_8000;
    // roughly twice the cycles the directed tests need
    localparam int watchdog_cycles = 200;

    logic                  clk;
    logic                  resetn;
    logic                  ms2ws_valid;
    logic [xlen-1:0]       ms_pc;
    logic [xlen-1:0]       ms_vaddr;
    logic                  ms_rf_we;
    logic [reg_addr_w-1:0] ms_rf_waddr;
    logic [xlen-1:0]       ms_rf_wdata;
    logic                  ms_csr_re;
    logic                  ms_csr_we;
    logic [csr_num_w-1:0]  ms_csr_num;
    logic [xlen-1:0]       ms_csr_wmask;
    logic [xlen-1:0]       ms_csr_wvalue;
    logic [except_w-1:0]   ms_except;
    logic                  ms_ertn;
    logic [reg_addr_w-1:0] rf_raddr;
    logic [xlen-1:0]       rf_rdata;
    logic [xlen-1:0]       debug_wb_pc;
    logic [3:0]            debug_wb_rf_we;
    logic [reg_addr_w-1:0] debug_wb_rf_wnum;
    logic [xlen-1:0]       debug_wb_rf_wdata;
    logic                  wb_ex;
    logic [ecode_w-1:0]    wb_ecode;
    logic [esubcode_w-1:0] wb_esubcode;
    logic                  ertn_flush;
    logic [xlen-1:0]       flush_pc;

    int error_count = 0;

    wb_subsystem_top #(
        .EENTRY_RESET (eentry_reset)
    ) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", watchdog_cycles);
        $display("sim failed");
        $finish;
    end

    task automatic check_word(input string name, input logic [xlen-1:0] got,
                              input logic [xlen-1:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_ecode(input string name, input logic [ecode_w-1:0] got,
                               input logic [ecode_w-1:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    // priority table, int highest and ale lowest
    function automatic logic [ecode_w-1:0] expected_ecode(input logic [except_w-1:0] flags);
        if (flags[0]) return ecode_int;
        if (flags[1]) return ecode_adef;
        if (flags[2]) return ecode_ine;
        if (flags[3]) return ecode_sys;
        if (flags[4]) return ecode_brk;
        return ecode_ale;
    endfunction

    task automatic clear_inputs();
        ms2ws_valid   = 1'b0;
        ms_pc         = '0;
        ms_vaddr      = '0;
        ms_rf_we      = 1'b0;
        ms_rf_waddr   = '0;
        ms_rf_wdata   = '0;
        ms_csr_re     = 1'b0;
        ms_csr_we     = 1'b0;
        ms_csr_num    = '0;
        ms_csr_wmask  = '0;
        ms_csr_wvalue = '0;
        ms_except     = '0;
        ms_ertn       = 1'b0;
    endtask

    // strobe the prepared fields, return in the middle of the writeback cycle
    task automatic strobe();
        ms2ws_valid = 1'b1;
        @(posedge clk);
        #1;
        clear_inputs();
        #4;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic read_reg(input logic [reg_addr_w-1:0] addr, output logic [xlen-1:0] value);
        rf_raddr = addr;
        #1;
        value = rf_rdata;
    endtask

    task automatic write_reg(input logic [reg_addr_w-1:0] addr, input logic [xlen-1:0] data);
        ms_pc       = $urandom;
        ms_rf_we    = 1'b1;
        ms_rf_waddr = addr;
        ms_rf_wdata = data;
        strobe();
        next_cycle();
    endtask

    task automatic csr_read(input logic [csr_num_w-1:0] num, output logic [xlen-1:0] value);
        ms_pc       = $urandom;
        ms_rf_we    = 1'b1;
        ms_rf_waddr = 5'd1;
        ms_csr_re   = 1'b1;
        ms_csr_num  = num;
        strobe();
        value = debug_wb_rf_wdata;
        next_cycle();
    endtask

    task automatic csr_write(input logic [csr_num_w-1:0] num, input logic [xlen-1:0] value,
                             input logic [xlen-1:0] mask);
        ms_pc         = $urandom;
        ms_csr_we     = 1'b1;
        ms_csr_num    = num;
        ms_csr_wvalue = value;
        ms_csr_wmask  = mask;
        strobe();
        next_cycle();
    endtask

    task automatic reset_state_test();
        logic [xlen-1:0] value;
        check_word("debug_wb_rf_we", {28'b0, debug_wb_rf_we}, 32'h0);
        check_bit("wb_ex", wb_ex, 1'b0);
        check_bit("ertn_flush", ertn_flush, 1'b0);
        csr_read(csr_crmd, value);
        check_word("crmd", value, 32'h0);
        csr_read(csr_eentry, value);
        check_word("eentry", value, eentry_reset);
    endtask

    task automatic plain_writeback_test();
        logic [xlen-1:0] pc;
        logic [xlen-1:0] data;
        logic [xlen-1:0] value;
        pc          = $urandom;
        data        = $urandom;
        ms_pc       = pc;
        ms_rf_we    = 1'b1;
        ms_rf_waddr = 5'd7;
        ms_rf_wdata = data;
        strobe();
        check_word("debug_wb_pc", debug_wb_pc, pc);
        check_word("debug_wb_rf_we", {28'b0, debug_wb_rf_we}, 32'hf);
        check_word("debug_wb_rf_wnum", {27'b0, debug_wb_rf_wnum}, 32'd7);
        check_word("debug_wb_rf_wdata", debug_wb_rf_wdata, data);
        next_cycle();
        read_reg(5'd7, value);
        check_word("rf_rdata r7", value, data);
        // r0 stays zero whatever is written
        write_reg(5'd0, $urandom);
        read_reg(5'd0, value);
        check_word("rf_rdata r0", value, 32'h0);
    endtask

    task automatic csr_access_test();
        logic [xlen-1:0] old_v;
        logic [xlen-1:0] new_v;
        logic [xlen-1:0] mask;
        logic [xlen-1:0] merged;
        logic [xlen-1:0] value;
        old_v  = $urandom;
        new_v  = $urandom;
        mask   = $urandom;
        merged = (old_v & ~mask) | (new_v & mask);
        // full-mask preload so the unmasked bits carry a known pattern
        csr_write(csr_save0, old_v, 32'hffff_ffff);
        csr_write(csr_save0, new_v, mask);
        csr_read(csr_save0, value);
        check_word("debug_wb_rf_wdata save0", value, merged);
        read_reg(5'd1, value);
        check_word("rf_rdata save0", value, merged);
    endtask

    task automatic exception_test(input logic [except_w-1:0] flags, output logic [xlen-1:0] pc);
        logic [xlen-1:0]    vaddr;
        logic [xlen-1:0]    value;
        logic [ecode_w-1:0] ecode;
        pc          = $urandom;
        vaddr       = $urandom;
        ecode       = expected_ecode(flags);
        ms_pc       = pc;
        ms_vaddr    = vaddr;
        ms_rf_we    = 1'b1;
        ms_rf_waddr = 5'd10;
        ms_rf_wdata = $urandom;
        ms_except   = flags;
        strobe();
        check_bit("wb_ex", wb_ex, 1'b1);
        check_ecode("wb_ecode", wb_ecode, ecode);
        check_word("wb_esubcode", {23'b0, wb_esubcode}, 32'h0);
        check_word("flush_pc", flush_pc, eentry_reset);
        check_word("debug_wb_rf_we", {28'b0, debug_wb_rf_we}, 32'h0);
        next_cycle();
        csr_read(csr_era, value);
        check_word("era", value, pc);
        csr_read(csr_estat, value);
        check_ecode("estat ecode", value[estat_ecode_hi:estat_ecode_lo], ecode);
        csr_read(csr_crmd, value);
        check_word("crmd plv", {30'b0, value[crmd_plv_hi:crmd_plv_lo]}, 32'h0);
        check_bit("crmd ie", value[crmd_ie], 1'b0);
        if (ecode == ecode_ale || ecode == ecode_adef) begin
            csr_read(csr_badv, value);
            check_word("badv", value, (ecode == ecode_ale) ? vaddr : pc);
        end
    endtask

    task automatic ertn_test();
        logic [xlen-1:0] ex_pc;
        logic [xlen-1:0] value;
        csr_write(csr_crmd, 32'h7, 32'h7);
        exception_test(6'b00_1000, ex_pc);
        ms_pc       = $urandom;
        ms_ertn     = 1'b1;
        ms_rf_we    = 1'b1;
        ms_rf_waddr = 5'd11;
        ms_rf_wdata = $urandom;
        strobe();
        check_bit("ertn_flush", ertn_flush, 1'b1);
        check_bit("wb_ex", wb_ex, 1'b0);
        check_word("flush_pc", flush_pc, ex_pc);
        check_word("debug_wb_rf_we", {28'b0, debug_wb_rf_we}, 32'h0);
        next_cycle();
        csr_read(csr_crmd, value);
        check_word("crmd plv", {30'b0, value[crmd_plv_hi:crmd_plv_lo]}, 32'h3);
        check_bit("crmd ie", value[crmd_ie], 1'b1);
    endtask

    task automatic flush_discard_test();
        logic [xlen-1:0] old_v;
        logic [xlen-1:0] value;
        old_v = $urandom;
        write_reg(5'd12, old_v);
        ms_pc     = $urandom;
        ms_except = 6'b00_1000;
        ms2ws_valid = 1'b1;
        @(posedge clk);
        #1;
        // second instruction arrives while the sys exception flushes
        clear_inputs();
        ms_pc       = $urandom;
        ms_rf_we    = 1'b1;
        ms_rf_waddr = 5'd12;
        ms_rf_wdata = ~old_v;
        strobe();
        check_word("debug_wb_rf_we", {28'b0, debug_wb_rf_we}, 32'h0);
        check_bit("wb_ex", wb_ex, 1'b0);
        next_cycle();
        read_reg(5'd12, value);
        check_word("rf_rdata r12", value, old_v);
    endtask

    initial begin
        logic [xlen-1:0] ex_pc;
        int unsigned     seed_init;
        seed_init = $urandom(32'h1ae1_fd6c);
        resetn   = 1'b0;
        rf_raddr = '0;
        clear_inputs();
        repeat (3) @(posedge clk);
        #1;
        resetn = 1'b1;

        reset_state_test();
        plain_writeback_test();
        csr_access_test();
        for (int i = 0; i < except_w; i++) begin
            exception_test(6'b1 << i, ex_pc);
        end
        // sys outranks brk
        exception_test(6'b01_1000, ex_pc);
        ertn_test();
        flush_discard_test();

        $display("tests done, %0d errors", error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* src/wb_subsystem_top.sv */
module wb_subsystem_top #(
    parameter logic [wb_pkg::xlen-1:0] EENTRY_RESET = 32'h1c00_8000
) (
    input  logic                          clk,
    input  logic                          resetn,
    // memory stage handoff
    input  logic                          ms2ws_valid,
    input  logic [wb_pkg::xlen-1:0]       ms_pc,
    input  logic [wb_pkg::xlen-1:0]       ms_vaddr,
    input  logic                          ms_rf_we,
    input  logic [wb_pkg::reg_addr_w-1:0] ms_rf_waddr,
    input  logic [wb_pkg::xlen-1:0]       ms_rf_wdata,
    input  logic                          ms_csr_re,
    input  logic                          ms_csr_we,
    input  logic [wb_pkg::csr_num_w-1:0]  ms_csr_num,
    input  logic [wb_pkg::xlen-1:0]       ms_csr_wmask,
    input  logic [wb_pkg::xlen-1:0]       ms_csr_wvalue,
    input  logic [wb_pkg::except_w-1:0]   ms_except,
    input  logic                          ms_ertn,
    // register observe port
    input  logic [wb_pkg::reg_addr_w-1:0] rf_raddr,
    output logic [wb_pkg::xlen-1:0]       rf_rdata,
    // trace
    output logic [wb_pkg::xlen-1:0]       debug_wb_pc,
    output logic [3:0]                    debug_wb_rf_we,
    output logic [wb_pkg::reg_addr_w-1:0] debug_wb_rf_wnum,
    output logic [wb_pkg::xlen-1:0]       debug_wb_rf_wdata,
    // redirect
    output logic                          wb_ex,
    output logic [wb_pkg::ecode_w-1:0]    wb_ecode,
    output logic [wb_pkg::esubcode_w-1:0] wb_esubcode,
    output logic                          ertn_flush,
    output logic [wb_pkg::xlen-1:0]       flush_pc
);
    import wb_pkg::*;

    logic                  rf_we;
    logic [reg_addr_w-1:0] rf_waddr;
    logic [xlen-1:0]       rf_wdata;

    csr_if u_csr_if ();

    wb_stage u_wb_stage (
        .clk               (clk),
        .resetn            (resetn),
        .ms2ws_valid       (ms2ws_valid),
        .ms_pc             (ms_pc),
        .ms_vaddr          (ms_vaddr),
        .ms_rf_we          (ms_rf_we),
        .ms_rf_waddr       (ms_rf_waddr),
        .ms_rf_wdata       (ms_rf_wdata),
        .ms_csr_re         (ms_csr_re),
        .ms_csr_we         (ms_csr_we),
        .ms_csr_num        (ms_csr_num),
        .ms_csr_wmask      (ms_csr_wmask),
        .ms_csr_wvalue     (ms_csr_wvalue),
        .ms_except         (ms_except),
        .ms_ertn           (ms_ertn),
        .csr               (u_csr_if.wb),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    csr_file #(
        .EENTRY_RESET (EENTRY_RESET)
    ) u_csr_file (
        .clk    (clk),
        .resetn (resetn),
        .csr    (u_csr_if.csr)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .resetn (resetn),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .raddr  (rf_raddr),
        .rdata  (rf_rdata)
    );

    assign wb_ex       = u_csr_if.wb_ex;
    assign wb_ecode    = u_csr_if.wb_ecode;
    assign wb_esubcode = u_csr_if.wb_esubcode;
    assign ertn_flush  = u_csr_if.ertn_flush;
    assign flush_pc    = u_csr_if.flush_pc;

endmodule

/* src/reg_file.sv */
module reg_file (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          we,
    input  logic [wb_pkg::reg_addr_w-1:0] waddr,
    input  logic [wb_pkg::xlen-1:0]       wdata,
    input  logic [wb_pkg::reg_addr_w-1:0] raddr,
    output logic [wb_pkg::xlen-1:0]       rdata
);
    import wb_pkg::*;

    // no storage behind r0
    logic [xlen-1:0] regs [1:(1 << reg_addr_w) - 1];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 1; i < (1 << reg_addr_w); i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata = (raddr == '0) ? '0 : regs[raddr];

endmodule

/* src/csr_file.sv */
module csr_file #(
    parameter logic [wb_pkg::xlen-1:0] EENTRY_RESET = '0
) (
    input  logic clk,
    input  logic resetn,
    csr_if.csr   csr
);
    import wb_pkg::*;

    logic [xlen-1:0] crmd;
    logic [xlen-1:0] prmd;
    logic [xlen-1:0] estat;
    logic [xlen-1:0] era;
    logic [xlen-1:0] badv;
    logic [xlen-1:0] eentry;
    logic [xlen-1:0] save [4];

    logic [xlen-1:0] rdata;
    logic            save_sel;

    function automatic logic [xlen-1:0] masked_write(
        input logic [xlen-1:0] old_v,
        input logic [xlen-1:0] new_v,
        input logic [xlen-1:0] mask
    );
        return (old_v & ~mask) | (new_v & mask);
    endfunction

    // save0..save3 share one aligned block of four numbers
    assign save_sel = (csr.csr_num[csr_num_w-1:2] == csr_save0[csr_num_w-1:2]);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd <= '0;
        end else if (csr.wb_ex) begin
            // enter kernel with interrupts off
            crmd[crmd_plv_hi:crmd_plv_lo] <= 2'd0;
            crmd[crmd_ie]                 <= 1'b0;
        end else if (csr.ertn_flush) begin
            crmd[crmd_plv_hi:crmd_plv_lo] <= prmd[crmd_plv_hi:crmd_plv_lo];
            crmd[crmd_ie]                 <= prmd[crmd_ie];
        end else if (csr.csr_we && csr.csr_num == csr_crmd) begin
            crmd <= masked_write(crmd, csr.csr_wvalue, csr.csr_wmask);
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            prmd  <= '0;
            estat <= '0;
            era   <= '0;
            badv  <= '0;
        end else if (csr.wb_ex) begin
            prmd[crmd_plv_hi:crmd_plv_lo]            <= crmd[crmd_plv_hi:crmd_plv_lo];
            prmd[crmd_ie]                            <= crmd[crmd_ie];
            estat[estat_ecode_hi:estat_ecode_lo]     <= csr.wb_ecode;
            estat[estat_esubcode_hi:estat_esubcode_lo] <= csr.wb_esubcode;
            era                                      <= csr.wb_pc;
            if (csr.badv_we) begin
                badv <= csr.wb_vaddr;
            end
        end else if (csr.csr_we) begin
            case (csr.csr_num)
                csr_prmd:  prmd  <= masked_write(prmd, csr.csr_wvalue, csr.csr_wmask);
                csr_estat: estat <= masked_write(estat, csr.csr_wvalue, csr.csr_wmask);
                csr_era:   era   <= masked_write(era, csr.csr_wvalue, csr.csr_wmask);
                csr_badv:  badv  <= masked_write(badv, csr.csr_wvalue, csr.csr_wmask);
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            eentry <= EENTRY_RESET;
            for (int i = 0; i < 4; i++) begin
                save[i] <= '0;
            end
        end else if (csr.csr_we) begin
            if (csr.csr_num == csr_eentry) begin
                eentry <= masked_write(eentry, csr.csr_wvalue, csr.csr_wmask);
            end
            if (save_sel) begin
                save[csr.csr_num[1:0]] <=
                    masked_write(save[csr.csr_num[1:0]], csr.csr_wvalue, csr.csr_wmask);
            end
        end
    end

    // read sees the value before any write in this cycle
    always_comb begin
        case (csr.csr_num)
            csr_crmd:   rdata = crmd;
            csr_prmd:   rdata = prmd;
            csr_estat:  rdata = estat;
            csr_era:    rdata = era;
            csr_badv:   rdata = badv;
            csr_eentry: rdata = eentry;
            csr_save0, csr_save1, csr_save2, csr_save3: rdata = save[csr.csr_num[1:0]];
            default:    rdata = '0;
        endcase
    end

    assign csr.csr_rvalue = csr.csr_re ? rdata : '0;
    assign csr.flush_pc   = csr.ertn_flush ? era : eentry;

    a_no_csr_we_on_ex: assert property (@(posedge clk) disable iff (!resetn)
        !(csr.csr_we && csr.wb_ex))
        else $error("csr write during exception");

endmodule

/* src/wb_stage.sv */
module wb_stage (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          ms2ws_valid,
    input  logic [wb_pkg::xlen-1:0]       ms_pc,
    input  logic [wb_pkg::xlen-1:0]       ms_vaddr,
    input  logic                          ms_rf_we,
    input  logic [wb_pkg::reg_addr_w-1:0] ms_rf_waddr,
    input  logic [wb_pkg::xlen-1:0]       ms_rf_wdata,
    input  logic                          ms_csr_re,
    input  logic                          ms_csr_we,
    input  logic [wb_pkg::csr_num_w-1:0]  ms_csr_num,
    input  logic [wb_pkg::xlen-1:0]       ms_csr_wmask,
    input  logic [wb_pkg::xlen-1:0]       ms_csr_wvalue,
    input  logic [wb_pkg::except_w-1:0]   ms_except,
    input  logic                          ms_ertn,
    csr_if.wb                             csr,
    output logic                          rf_we,
    output logic [wb_pkg::reg_addr_w-1:0] rf_waddr,
    output logic [wb_pkg::xlen-1:0]       rf_wdata,
    output logic [wb_pkg::xlen-1:0]       debug_wb_pc,
    output logic [3:0]                    debug_wb_rf_we,
    output logic [wb_pkg::reg_addr_w-1:0] debug_wb_rf_wnum,
    output logic [wb_pkg::xlen-1:0]       debug_wb_rf_wdata
);
    import wb_pkg::*;

    logic                  ws_valid;
    logic [xlen-1:0]       ws_pc;
    logic [xlen-1:0]       ws_vaddr;
    logic                  ws_rf_we;
    logic [reg_addr_w-1:0] ws_rf_waddr;
    logic [xlen-1:0]       ws_rf_wdata;
    logic                  ws_csr_re;
    logic                  ws_csr_we;
    logic [csr_num_w-1:0]  ws_csr_num;
    logic [xlen-1:0]       ws_csr_wmask;
    logic [xlen-1:0]       ws_csr_wvalue;
    logic [except_w-1:0]   ws_except;
    logic                  ws_ertn;

    logic                  ex_any;
    logic                  flush;
    logic [ecode_w-1:0]    ex_ecode;
    logic                  ex_badv;
    logic [xlen-1:0]       ex_bad_addr;

    // ready-go is always true, so a flush is the only thing that empties the stage
    always_ff @(posedge clk) begin
        if (!resetn) begin
            ws_valid <= 1'b0;
        end else if (flush) begin
            ws_valid <= 1'b0;
        end else begin
            ws_valid <= ms2ws_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms2ws_valid) begin
            ws_pc         <= ms_pc;
            ws_vaddr      <= ms_vaddr;
            ws_rf_we      <= ms_rf_we;
            ws_rf_waddr   <= ms_rf_waddr;
            ws_rf_wdata   <= ms_rf_wdata;
            ws_csr_re     <= ms_csr_re;
            ws_csr_we     <= ms_csr_we;
            ws_csr_num    <= ms_csr_num;
            ws_csr_wmask  <= ms_csr_wmask;
            ws_csr_wvalue <= ms_csr_wvalue;
            ws_except     <= ms_except;
            ws_ertn       <= ms_ertn;
        end
    end

    assign ex_any = ws_valid && (|ws_except);
    assign flush  = csr.wb_ex || csr.ertn_flush;

    // highest priority flag wins
    always_comb begin
        ex_ecode    = ecode_int;
        ex_badv     = 1'b0;
        ex_bad_addr = ws_vaddr;
        if (ws_except[exc_int]) begin
            ex_ecode = ecode_int;
        end else if (ws_except[exc_adef]) begin
            ex_ecode    = ecode_adef;
            ex_badv     = 1'b1;
            // fetch fault, the pc itself is the bad address
            ex_bad_addr = ws_pc;
        end else if (ws_except[exc_ine]) begin
            ex_ecode = ecode_ine;
        end else if (ws_except[exc_sys]) begin
            ex_ecode = ecode_sys;
        end else if (ws_except[exc_brk]) begin
            ex_ecode = ecode_brk;
        end else if (ws_except[exc_ale]) begin
            ex_ecode = ecode_ale;
            ex_badv  = 1'b1;
        end
    end

    assign csr.wb_ex       = ex_any;
    assign csr.wb_ecode    = ex_ecode;
    assign csr.wb_esubcode = '0;
    assign csr.wb_pc       = ws_pc;
    assign csr.wb_vaddr    = ex_bad_addr;
    assign csr.badv_we     = ex_any && ex_badv;
    // an ertn that also carries a fault is taken as the fault
    assign csr.ertn_flush  = ws_valid && ws_ertn && !ex_any;

    assign csr.csr_num    = ws_csr_num;
    assign csr.csr_re     = ws_valid && ws_csr_re;
    assign csr.csr_we     = ws_valid && ws_csr_we && !ex_any;
    assign csr.csr_wmask  = ws_csr_wmask;
    assign csr.csr_wvalue = ws_csr_wvalue;

    // register write only for a clean retire
    assign rf_we    = ws_valid && ws_rf_we && !ex_any && !ws_ertn;
    assign rf_waddr = ws_rf_waddr;
    assign rf_wdata = ws_csr_re ? csr.csr_rvalue : ws_rf_wdata;

    assign debug_wb_pc       = ws_pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = ws_rf_waddr;
    assign debug_wb_rf_wdata = rf_wdata;

    // the instruction behind a flush must leave no trace
    a_quiet_after_flush: assert property (@(posedge clk) disable iff (!resetn)
        flush |=> !(rf_we || csr.csr_we || csr.wb_ex || csr.ertn_flush))
        else $error("side effect in the cycle after a flush");

endmodule

/* src/csr_if.sv */
interface csr_if;
    import wb_pkg::*;

    // csr access from writeback
    logic [csr_num_w-1:0]  csr_num;
    logic                  csr_re;
    logic                  csr_we;
    logic [xlen-1:0]       csr_wmask;
    logic [xlen-1:0]       csr_wvalue;
    logic [xlen-1:0]       csr_rvalue;

    // exception and return handshake
    logic                  wb_ex;
    logic [ecode_w-1:0]    wb_ecode;
    logic [esubcode_w-1:0] wb_esubcode;
    logic [xlen-1:0]       wb_pc;
    logic [xlen-1:0]       wb_vaddr;
    logic                  badv_we;
    logic                  ertn_flush;
    logic [xlen-1:0]       flush_pc;

    modport wb (
        output csr_num, csr_re, csr_we, csr_wmask, csr_wvalue,
        output wb_ex, wb_ecode, wb_esubcode, wb_pc, wb_vaddr, badv_we, ertn_flush,
        input  csr_rvalue, flush_pc
    );

    modport csr (
        input  csr_num, csr_re, csr_we, csr_wmask, csr_wvalue,
        input  wb_ex, wb_ecode, wb_esubcode, wb_pc, wb_vaddr, badv_we, ertn_flush,
        output csr_rvalue, flush_pc
    );

endinterface

/* src/wb_pkg.sv */
package wb_pkg;

    // datapath and field widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int csr_num_w  = 14;
    localparam int ecode_w    = 6;
    localparam int esubcode_w = 9;

    // exception flags from the memory stage, listed from highest priority
    typedef enum logic [2:0] {
        exc_int  = 3'd0,
        exc_adef = 3'd1,
        exc_ine  = 3'd2,
        exc_sys  = 3'd3,
        exc_brk  = 3'd4,
        exc_ale  = 3'd5
    } except_t;

    localparam int except_w = 6;

    // ecode values written into estat
    localparam logic [ecode_w-1:0] ecode_int  = 6'h0;
    localparam logic [ecode_w-1:0] ecode_adef = 6'h8;
    localparam logic [ecode_w-1:0] ecode_ale  = 6'h9;
    localparam logic [ecode_w-1:0] ecode_sys  = 6'hb;
    localparam logic [ecode_w-1:0] ecode_brk  = 6'hc;
    localparam logic [ecode_w-1:0] ecode_ine  = 6'hd;

    // implemented csr numbers
    localparam logic [csr_num_w-1:0] csr_crmd   = 14'h00;
    localparam logic [csr_num_w-1:0] csr_prmd   = 14'h01;
    localparam logic [csr_num_w-1:0] csr_estat  = 14'h05;
    localparam logic [csr_num_w-1:0] csr_era    = 14'h06;
    localparam logic [csr_num_w-1:0] csr_badv   = 14'h07;
    localparam logic [csr_num_w-1:0] csr_eentry = 14'h0c;
    localparam logic [csr_num_w-1:0] csr_save0  = 14'h30;
    localparam logic [csr_num_w-1:0] csr_save1  = 14'h31;
    localparam logic [csr_num_w-1:0] csr_save2  = 14'h32;
    localparam logic [csr_num_w-1:0] csr_save3  = 14'h33;

    // field positions, prmd shares the crmd layout for plv and ie
    localparam int crmd_plv_lo       = 0;
    localparam int crmd_plv_hi       = 1;
    localparam int crmd_ie           = 2;
    localparam int estat_ecode_lo    = 16;
    localparam int estat_ecode_hi    = 21;
    localparam int estat_esubcode_lo = 22;
    localparam int estat_esubcode_hi = 30;

endpackage
